// ==== Makefile ====
# Verilator build and run for the ALU testbench

VERILATOR ?= verilator
TOP       ?= alu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/alu_byte_lane.sv ====
// ALU byte lane
`timescale 1ns/1ps
`default_nettype none

module alu_byte_lane import alu_pkg::*; #(
    parameter int LANE_IDX = 0
) (
    input  lane_t    a,
    input  lane_t    b,
    input  lane_fn_t fn,
    input  logic     carry_in,
    input  logic     shl_in,
    input  logic     shr_in,
    output lane_t    rslt,
    output logic     carry_out,
    output logic     ovf_out,
    output logic     half_out
);

    localparam int MSB = LANE_W - 1;
    localparam int NIB = LANE_W / 2;

    logic [NIB:0] lo_add;
    logic [NIB:0] hi_add;
    logic [NIB:0] lo_sub;
    logic [NIB:0] hi_sub;
    lane_t        sum;
    lane_t        dif;
    logic         add_ovf;
    logic         sub_ovf;
    logic         nib_c;

    // nibble split gives the half carry for free
    assign lo_add = {1'b0, a[NIB-1:0]} + {1'b0, b[NIB-1:0]} + {{NIB{1'b0}}, carry_in};
    assign hi_add = {1'b0, a[MSB:NIB]} + {1'b0, b[MSB:NIB]} + {{NIB{1'b0}}, lo_add[NIB]};

    // top bit of each difference is the borrow
    assign lo_sub = {1'b0, a[NIB-1:0]} - {1'b0, b[NIB-1:0]} - {{NIB{1'b0}}, carry_in};
    assign hi_sub = {1'b0, a[MSB:NIB]} - {1'b0, b[MSB:NIB]} - {{NIB{1'b0}}, lo_sub[NIB]};

    assign sum = {hi_add[NIB-1:0], lo_add[NIB-1:0]};
    assign dif = {hi_sub[NIB-1:0], lo_sub[NIB-1:0]};

    assign add_ovf = (a[MSB] == b[MSB]) & (sum[MSB] != a[MSB]);
    assign sub_ovf = (a[MSB] != b[MSB]) & (dif[MSB] != a[MSB]);

    always_comb begin
        rslt      = b;      // pass
        carry_out = 1'b0;
        ovf_out   = 1'b0;
        nib_c     = 1'b0;
        case (fn)
            FN_ADD: begin
                rslt      = sum;
                carry_out = hi_add[NIB];
                ovf_out   = add_ovf;
                nib_c     = lo_add[NIB];
            end
            FN_SUB: begin
                rslt      = dif;
                carry_out = hi_sub[NIB];
                ovf_out   = sub_ovf;
                nib_c     = lo_sub[NIB];
            end
            FN_AND: rslt = a & b;
            FN_OR:  rslt = a | b;
            FN_XOR: rslt = a ^ b;
            FN_INV: rslt = ~b;
            FN_SHL: begin
                rslt      = {a[MSB-1:0], shl_in};
                carry_out = a[MSB];
            end
            FN_SHR: begin
                rslt      = {shr_in, a[MSB:1]};
                carry_out = a[0];
            end
            default: ;
        endcase
    end

    // only the bottom lane holds bit 3
    assign half_out = (LANE_IDX == 0) ? nib_c : 1'b0;

endmodule

`default_nettype wire

// ==== design/alu_flag_writeback.sv ====
// ALU flags and write-back
`timescale 1ns/1ps
`default_nettype none

module alu_flag_writeback import alu_pkg::*; #(
    parameter int NUM_LANES = alu_pkg::NUM_LANES,
    parameter int LANE_W    = alu_pkg::LANE_W
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  width_t      w,
    input  logic        flag_we,
    input  flag_class_t flag_class,
    input  logic [1:0]  carry_fn,
    input  data_t       lane_rslt,
    input  lane_mask_t  lane_carry,
    input  lane_mask_t  lane_ovf,
    input  logic        half,
    output data_t       dout,
    output flags_t      flags,
    output width_t      alu_we,
    output logic        flag_only,
    output logic        carry
);

    lane_mask_t lane_en;
    lane_mask_t top_lane;
    lane_mask_t lane_msb;
    data_t      rslt;
    logic       sign;
    logic       zero;
    logic       parity;
    logic       top_carry;
    logic       top_ovf;
    logic       shift_c;
    logic       flag_s, flag_z, flag_h, flag_v, flag_n;
    logic       nx_s, nx_z, nx_h, nx_v, nx_n, nx_c;
    logic       flag_wel;
    logic       flag_load;

    always_comb begin
        lane_en  = '0;
        top_lane = '0;
        if (w[0]) begin
            lane_en[0]  = 1'b1;
            top_lane[0] = 1'b1;
        end else if (w[1]) begin
            lane_en[1:0] = 2'b11;
            top_lane[1]  = 1'b1;
        end else begin
            lane_en               = '1;
            top_lane[NUM_LANES-1] = 1'b1;
        end
    end

    // zero-extend above the width
    genvar i;
    generate
        for (i = 0; i < NUM_LANES; i++) begin : g_lane
            assign rslt[LANE_W*i +: LANE_W] = lane_en[i] ? lane_rslt[LANE_W*i +: LANE_W] : '0;
            assign lane_msb[i] = rslt[LANE_W*i + LANE_W - 1];
        end
    endgenerate

    assign sign      = |(top_lane & lane_msb);
    assign zero      = rslt == '0;
    assign parity    = ~^rslt[2*LANE_W-1:0];  // even parity of the masked result
    assign top_carry = |(top_lane & lane_carry);
    assign top_ovf   = |(top_lane & lane_ovf);
    assign shift_c   = (flag_class == FC_SHR) ? lane_carry[0] : top_carry;
    assign flag_load = (w != '0) || (flag_we && !flag_wel);

    always_comb begin
        {nx_s, nx_z, nx_h, nx_v, nx_n, nx_c} = {flag_s, flag_z, flag_h, flag_v, flag_n, carry};
        case (flag_class)
            FC_ARITH: begin
                {nx_s, nx_z, nx_h, nx_v} = {sign, zero, half, top_ovf};
                nx_n = carry_fn[0];
                nx_c = shift_c;
            end
            FC_LOGIC_H, FC_LOGIC: begin
                {nx_s, nx_z, nx_v} = {sign, zero, parity};
                nx_h = flag_class == FC_LOGIC_H;
                nx_n = 1'b0;
                nx_c = 1'b0;
            end
            FC_SHL, FC_SHR: begin
                {nx_s, nx_z, nx_h, nx_v} = {sign, zero, 1'b0, parity};
                nx_n = 1'b0;
                nx_c = shift_c;
            end
            FC_CARRY: begin
                nx_n = 1'b0;
                case (carry_fn)
                    CF_SET: {nx_h, nx_c} = 2'b01;
                    CF_CLR: {nx_h, nx_c} = 2'b00;
                    CF_INV: nx_c = ~carry;
                    default: nx_c = ~flag_z;
                endcase
            end
            FC_CPL: begin
                nx_h = 1'b1;
                nx_n = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout      <= '0;
            {flag_s, flag_z, flag_h, flag_v, flag_n, carry} <= '0;
            alu_we    <= '0;
            flag_only <= 1'b0;
            flag_wel  <= 1'b0;
        end else if (cen) begin
            flag_wel  <= flag_we;
            alu_we    <= w;
            flag_only <= flag_we;
            if (w != '0)
                dout <= rslt;
            if (flag_load)
                {flag_s, flag_z, flag_h, flag_v, flag_n, carry} <= {nx_s, nx_z, nx_h, nx_v, nx_n, nx_c};
        end
    end

    assign flags = {flag_s, flag_z, 1'b0, flag_h, 1'b0, flag_v, flag_n, carry};

endmodule

`default_nettype wire

// ==== design/alu_operand_feed.sv ====
// ALU operand feed and decode
`timescale 1ns/1ps
`default_nettype none

module alu_operand_feed import alu_pkg::*; #(
    parameter int NUM_LANES = alu_pkg::NUM_LANES,
    parameter int LANE_W    = alu_pkg::LANE_W
) (
    input  data_t       op0,
    input  data_t       op1,
    input  data_t       imm,
    input  logic        sel_imm,
    input  alu_op_t     sel,
    input  width_t      w,
    input  logic        carry,
    output data_t       op_b,
    output lane_fn_t    lane_fn,
    output logic        carry_in0,
    output lane_mask_t  shl_fill,
    output lane_mask_t  shr_fill,
    output flag_class_t flag_class,
    output logic [1:0]  carry_fn
);

    localparam int MSB = NUM_LANES * LANE_W - 1;

    logic       width_msb;
    logic       lsb_fill;
    logic       msb_fill;
    lane_mask_t top_lane;

    assign op_b      = sel_imm ? imm : op1;
    assign width_msb = w[0] ? op0[LANE_W-1] : w[1] ? op0[2*LANE_W-1] : op0[MSB];
    assign lsb_fill  = (sel == ALU_RL) ? carry : (sel == ALU_RLC) ? width_msb : 1'b0;
    assign msb_fill  = (sel == ALU_RR)  ? carry :
                       (sel == ALU_SRA) ? width_msb :
                       (sel == ALU_RRC) ? op0[0] : 1'b0;

    always_comb begin
        top_lane = '0;
        if (w[0])
            top_lane[0] = 1'b1;
        else if (w[1])
            top_lane[1] = 1'b1;
        else
            top_lane[NUM_LANES-1] = 1'b1;
    end

    always_comb begin
        lane_fn    = FN_PASS;   // MOVE and NOP
        flag_class = FC_KEEP;
        carry_fn   = CF_SET;
        carry_in0  = 1'b0;
        case (sel)
            ALU_ADD, ALU_ADC: begin
                lane_fn    = FN_ADD;
                flag_class = FC_ARITH;
                carry_in0  = (sel == ALU_ADC) & carry;
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                lane_fn    = FN_SUB;
                flag_class = FC_ARITH;
                carry_fn   = 2'd1;  // bit 0 gives N for arithmetic
                carry_in0  = (sel == ALU_SBC) & carry;
            end
            ALU_AND: begin
                lane_fn    = FN_AND;
                flag_class = FC_LOGIC_H;
            end
            ALU_OR: begin
                lane_fn    = FN_OR;
                flag_class = FC_LOGIC;
            end
            ALU_XOR: begin
                lane_fn    = FN_XOR;
                flag_class = FC_LOGIC;
            end
            ALU_CPL: begin
                lane_fn    = FN_INV;
                flag_class = FC_CPL;
            end
            ALU_RL, ALU_RLC, ALU_SLA, ALU_SLL: begin
                lane_fn    = FN_SHL;
                flag_class = FC_SHL;
            end
            ALU_RR, ALU_RRC, ALU_SRA, ALU_SRL: begin
                lane_fn    = FN_SHR;
                flag_class = FC_SHR;
            end
            ALU_SCF: flag_class = FC_CARRY;
            ALU_RCF: begin
                flag_class = FC_CARRY;
                carry_fn   = CF_CLR;
            end
            ALU_CCF: begin
                flag_class = FC_CARRY;
                carry_fn   = CF_INV;
            end
            ALU_ZCF: begin
                flag_class = FC_CARRY;
                carry_fn   = CF_NZ;
            end
            default: ;
        endcase
    end

    // lane boundary bits, wrapped at the active width
    genvar i;
    generate
        for (i = 0; i < NUM_LANES; i++) begin : g_fill
            if (i == 0) begin : g_lsb
                assign shl_fill[i] = lsb_fill;
            end else begin : g_shl
                assign shl_fill[i] = op0[LANE_W*i-1];
            end
            if (i == NUM_LANES - 1) begin : g_msb
                assign shr_fill[i] = msb_fill;
            end else begin : g_shr
                assign shr_fill[i] = top_lane[i] ? msb_fill : op0[LANE_W*(i+1)];
            end
        end
    endgenerate

endmodule

`default_nettype wire

// ==== design/alu_pkg.sv ====
// ALU shared types
`default_nettype none

package alu_pkg;

    parameter int DATA_W    = 32;
    parameter int LANE_W    = 8;
    parameter int NUM_LANES = DATA_W / LANE_W;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [LANE_W-1:0]    lane_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [2:0]           width_t;    // one-hot, bit 0 byte, bit 2 long
    typedef logic [7:0]           flags_t;    // S Z 0 H 0 V N C

    typedef enum logic [4:0] {
        ALU_MOVE,
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP,
        ALU_AND, ALU_OR, ALU_XOR, ALU_CPL,
        ALU_RL, ALU_RR, ALU_RLC, ALU_RRC,
        ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL,
        ALU_SCF, ALU_RCF, ALU_CCF, ALU_ZCF,
        ALU_NOP
    } alu_op_t;

    // nine lane functions, so four bits
    typedef enum logic [3:0] {
        FN_PASS,
        FN_ADD,
        FN_SUB,
        FN_AND,
        FN_OR,
        FN_XOR,
        FN_INV,
        FN_SHL,
        FN_SHR
    } lane_fn_t;

    typedef enum logic [2:0] {
        FC_KEEP,
        FC_ARITH,
        FC_LOGIC_H,     // H set
        FC_LOGIC,       // H clear
        FC_SHL,
        FC_SHR,
        FC_CARRY,
        FC_CPL
    } flag_class_t;

    // carry flag operations
    parameter logic [1:0] CF_SET = 2'd0;
    parameter logic [1:0] CF_CLR = 2'd1;
    parameter logic [1:0] CF_INV = 2'd2;
    parameter logic [1:0] CF_NZ  = 2'd3;

endpackage

`default_nettype wire

// ==== design/alu_top.sv ====
// 32-bit lane ALU
`timescale 1ns/1ps
`default_nettype none

module alu_top import alu_pkg::*; #(
    parameter int NUM_LANES = alu_pkg::NUM_LANES,
    parameter int LANE_W    = alu_pkg::LANE_W
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    cen,
    input  data_t   op0,        // destination
    input  data_t   op1,        // source
    input  data_t   imm,
    input  logic    sel_imm,
    input  alu_op_t sel,
    input  width_t  w,
    input  logic    flag_we,
    output data_t   dout,
    output flags_t  flags,
    output width_t  alu_we,
    output logic    flag_only
);

    data_t              op_b;
    lane_fn_t           lane_fn;
    lane_mask_t         shl_fill;
    lane_mask_t         shr_fill;
    flag_class_t        flag_class;
    logic [1:0]         carry_fn;
    logic               carry;
    logic               carry_in0;
    data_t              lane_rslt;
    lane_mask_t         lane_carry;
    lane_mask_t         lane_ovf;
    lane_mask_t         lane_half;

    alu_operand_feed #(.NUM_LANES(NUM_LANES), .LANE_W(LANE_W)) u_feed (
        .op0        (op0),
        .op1        (op1),
        .imm        (imm),
        .sel_imm    (sel_imm),
        .sel        (sel),
        .w          (w),
        .carry      (carry),
        .op_b       (op_b),
        .lane_fn    (lane_fn),
        .carry_in0  (carry_in0),
        .shl_fill   (shl_fill),
        .shr_fill   (shr_fill),
        .flag_class (flag_class),
        .carry_fn   (carry_fn)
    );

    genvar i;
    generate
        for (i = 0; i < NUM_LANES; i++) begin : g_lane
            logic cin;
            logic cout;     // carry to the next lane
            if (i == 0) begin : g_first
                assign cin = carry_in0;
            end else begin : g_next
                assign cin = g_lane[i-1].cout;
            end
            alu_byte_lane #(.LANE_IDX(i)) u_lane (
                .a         (op0[LANE_W*i +: LANE_W]),
                .b         (op_b[LANE_W*i +: LANE_W]),
                .fn        (lane_fn),
                .carry_in  (cin),
                .shl_in    (shl_fill[i]),
                .shr_in    (shr_fill[i]),
                .rslt      (lane_rslt[LANE_W*i +: LANE_W]),
                .carry_out (cout),
                .ovf_out   (lane_ovf[i]),
                .half_out  (lane_half[i])
            );
            assign lane_carry[i] = cout;
        end
    endgenerate

    // upper lanes drive half_out low
    alu_flag_writeback #(.NUM_LANES(NUM_LANES), .LANE_W(LANE_W)) u_wb (
        .clk (clk), .rst (rst), .cen (cen),
        .w (w), .flag_we (flag_we), .flag_class (flag_class), .carry_fn (carry_fn),
        .lane_rslt (lane_rslt), .lane_carry (lane_carry), .lane_ovf (lane_ovf),
        .half (|lane_half),
        .dout (dout), .flags (flags), .alu_we (alu_we), .flag_only (flag_only),
        .carry (carry)
    );

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
design/alu_pkg.sv
design/alu_operand_feed.sv
design/alu_byte_lane.sv
design/alu_flag_writeback.sv
design/alu_top.sv
tests/alu_tb.sv

// ==== include/alu_tb_cases.svh ====
// ALU test case table
// rnd, op0, op1, imm, sel_imm, sel, w, flag_we, expected dout, expected flags (S Z 0 H 0 V N C)

localparam int NUM_CASES = 50;

case_t case_tab [NUM_CASES] = '{
    '{0, 'haabb0012, 'hffff0034, 'h0, 0, ALU_ADD, W_B, 0, 'h46, 'h00},
    '{0, 'h000000ff, 'h00000001, 'h0, 0, ALU_ADD, W_B, 0, 'h00, 'h51},
    '{0, 'h00000010, 'h00000020, 'h0, 0, ALU_ADC, W_B, 0, 'h31, 'h00},  // carry in
    '{0, 'h0000007f, 'h00000001, 'h0, 0, ALU_ADD, W_B, 0, 'h80, 'h94},
    '{0, 'h00001234, 'h0000dead, 'h0f0f, 1, ALU_ADD, W_W, 0, 'h2143, 'h10},
    '{0, 'hffffffff, 'h00000001, 'h0, 0, ALU_ADD, W_L, 0, 'h0, 'h51},
    '{0, 'h7fffffff, 'h00000000, 'h0, 0, ALU_ADC, W_L, 0, 'h80000000, 'h94},
    '{0, 'h00000050, 'h00000020, 'h0, 0, ALU_SUB, W_B, 0, 'h30, 'h02},
    '{0, 'h00000000, 'h00000001, 'h0, 0, ALU_SUB, W_B, 0, 'hff, 'h93},
    '{0, 'h00008000, 'h00000001, 'h0, 0, ALU_SBC, W_W, 0, 'h7ffe, 'h16},
    '{0, 'h12345678, 'h12345678, 'h0, 0, ALU_CP, W_L, 0, 'h0, 'h42},
    '{0, 'h000000f3, 'h0000003c, 'h0, 0, ALU_AND, W_B, 0, 'h30, 'h14},
    '{0, 'h00008001, 'h00000100, 'h0, 0, ALU_OR, W_W, 0, 'h8101, 'h80},
    '{0, 'hffff0000, 'hffff0000, 'h0, 0, ALU_XOR, W_L, 0, 'h0, 'h44},
    '{0, 'h12340001, 'h00000000, 'h0, 0, ALU_XOR, W_L, 0, 'h12340001, 'h00},  // 16-bit parity
    '{0, 'h00000055, 'h0000000f, 'h0, 0, ALU_CPL, W_B, 0, 'hf0, 'h12},
    '{0, 'h00000000, 'h00005555, 'habcd1234, 1, ALU_MOVE, W_W, 0, 'h1234, 'h12},
    '{0, 'h00000081, 'h0, 'h0, 0, ALU_SLA, W_B, 0, 'h02, 'h01},
    '{0, 'h00000040, 'h0, 'h0, 0, ALU_RL, W_B, 0, 'h81, 'h84},
    '{0, 'h00008000, 'h0, 'h0, 0, ALU_RLC, W_W, 0, 'h0001, 'h01},
    '{0, 'h00000002, 'h0, 'h0, 0, ALU_RR, W_W, 0, 'h8001, 'h84},
    '{0, 'h00000001, 'h0, 'h0, 0, ALU_RRC, W_L, 0, 'h80000000, 'h85},
    '{0, 'h80000002, 'h0, 'h0, 0, ALU_SRA, W_L, 0, 'hc0000001, 'h80},
    '{0, 'hffffff01, 'h0, 'h0, 0, ALU_SRL, W_B, 0, 'h0, 'h45},
    '{0, 'hc0000000, 'h0, 'h0, 0, ALU_SLL, W_L, 0, 'h80000000, 'h85},
    '{0, 'h00000280, 'h0, 'h0, 0, ALU_SRA, W_B, 0, 'hc0, 'h84},  // no fill from lane 1
    '{0, 'h00ff4080, 'h0, 'h0, 0, ALU_SLL, W_W, 0, 'h8100, 'h84},
    '{0, 'h00010100, 'h0, 'h0, 0, ALU_SRL, W_W, 0, 'h0080, 'h00},
    '{0, 'h0, 'h0, 'h0, 0, ALU_SCF, 3'b000, 1, 'h0080, 'h01},
    '{0, 'h0, 'h0, 'h0, 0, ALU_NOP, 3'b000, 0, 'h0080, 'h01},
    '{0, 'h0, 'h0, 'h0, 0, ALU_CCF, 3'b000, 1, 'h0080, 'h00},
    '{0, 'h0, 'h0, 'h0, 0, ALU_NOP, 3'b000, 0, 'h0080, 'h00},
    '{0, 'h0, 'h0, 'h0, 0, ALU_ZCF, 3'b000, 1, 'h0080, 'h01},
    '{0, 'h0, 'h0, 'h0, 0, ALU_NOP, 3'b000, 0, 'h0080, 'h01},
    '{0, 'h0, 'h0, 'h0, 0, ALU_RCF, 3'b000, 1, 'h0080, 'h00},
    '{0, 'h0, 'h0, 'h0, 0, ALU_SCF, 3'b000, 1, 'h0080, 'h00},  // flag_we held, no edge
    '{0, 'h0, 'h0, 'h0, 0, ALU_NOP, 3'b000, 0, 'h0080, 'h00},
    // random operands
    '{1, 'h0, 'h0, 'h0, 0, ALU_ADD, W_L, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 1, ALU_ADD, W_W, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 0, ALU_SUB, W_W, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 0, ALU_ADC, W_B, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 0, ALU_SBC, W_L, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 0, ALU_CP, W_B, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 0, ALU_XOR, W_W, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 0, ALU_AND, W_B, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 0, ALU_RL, W_L, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 0, ALU_SRA, W_W, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 0, ALU_RRC, W_B, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 0, ALU_OR, W_L, 0, 'h0, 'h00},
    '{1, 'h0, 'h0, 'h0, 1, ALU_CPL, W_W, 0, 'h0, 'h00}
};

// ==== tests/alu_tb.sv ====
// ALU testbench
`timescale 1ns/1ps
`default_nettype none

module alu_tb import alu_pkg::*;;

    localparam int     CLK_PERIOD = 8;
    localparam int     DRIVE_DLY  = 1;
    localparam width_t W_B        = 3'b001;
    localparam width_t W_W        = 3'b010;
    localparam width_t W_L        = 3'b100;

    typedef struct packed {
        logic    rnd;       // operands from $random, expected from the model
        data_t   op0;
        data_t   op1;
        data_t   imm;
        logic    sel_imm;
        alu_op_t sel;
        width_t  w;
        logic    flag_we;
        data_t   exp_dout;
        flags_t  exp_flags;
    } case_t;

`include "alu_tb_cases.svh"

    logic    clk;
    logic    rst;
    logic    cen;
    data_t   op0;
    data_t   op1;
    data_t   imm;
    logic    sel_imm;
    alu_op_t sel;
    width_t  w;
    logic    flag_we;
    data_t   dout;
    flags_t  flags;
    width_t  alu_we;
    logic    flag_only;
    integer  seed;

    alu_top alu_top_inst (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .op0       (op0),
        .op1       (op1),
        .imm       (imm),
        .sel_imm   (sel_imm),
        .sel       (sel),
        .w         (w),
        .flag_we   (flag_we),
        .dout      (dout),
        .flags     (flags),
        .alu_we    (alu_we),
        .flag_only (flag_only)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_CASES + 10) * CLK_PERIOD);
        $display("watchdog expired before all cases were applied");
        $display("STATUS: FAIL");
        $fatal(1, "simulation timed out");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic logic even_parity(input data_t r, input width_t wd);
        even_parity = wd[0] ? ~^r[7:0] : ~^r[15:0];
    endfunction

    // expected {flags, dout} for an operation with a nonzero width
    function automatic logic [39:0] ref_result(input alu_op_t op, input data_t a,
                                               input data_t b, input width_t wd,
                                               input flags_t f_in);
        int          n;
        data_t       mask;
        data_t       a_m;
        data_t       b_m;
        data_t       r;
        logic [32:0] full;
        logic [4:0]  nib;
        logic        cin, amsb, fill;
        logic        s, z, h, v, nf, c;
        n    = wd[0] ? 8 : (wd[1] ? 16 : 32);
        mask = (n == 32) ? 32'hffffffff : ((32'd1 << n) - 32'd1);
        a_m  = a & mask;
        b_m  = b & mask;
        amsb = a[n-1];
        {s, z, h, v, nf, c} = {f_in[7], f_in[6], f_in[4], f_in[2], f_in[1], f_in[0]};
        cin  = ((op == ALU_ADC) || (op == ALU_SBC)) && f_in[0];
        r    = b_m;
        case (op)
            ALU_ADD, ALU_ADC: begin
                full = {1'b0, a_m} + {1'b0, b_m} + 33'(cin);
                r    = full[31:0] & mask;
                c    = full[n];
                nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(cin);
                h    = nib[4];
                v    = (amsb == b[n-1]) && (r[n-1] != amsb);
                nf   = 1'b0;
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                r  = (a_m - b_m - 32'(cin)) & mask;
                c  = {1'b0, a_m} < ({1'b0, b_m} + 33'(cin));
                h  = {1'b0, a[3:0]} < ({1'b0, b[3:0]} + 5'(cin));
                v  = (amsb != b[n-1]) && (r[n-1] != amsb);
                nf = 1'b1;
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                r  = (op == ALU_AND) ? (a_m & b_m) : (op == ALU_OR) ? (a_m | b_m) : (a_m ^ b_m);
                h  = (op == ALU_AND);
                v  = even_parity(r, wd);
                nf = 1'b0;
                c  = 1'b0;
            end
            ALU_CPL: begin
                r  = ~b & mask;
                h  = 1'b1;
                nf = 1'b1;
            end
            ALU_RL, ALU_RLC, ALU_SLA, ALU_SLL: begin
                fill = (op == ALU_RL) ? f_in[0] : (op == ALU_RLC) ? amsb : 1'b0;
                r    = ((a_m << 1) | 32'(fill)) & mask;
                c    = amsb;
            end
            ALU_RR, ALU_RRC, ALU_SRA, ALU_SRL: begin
                fill = (op == ALU_RR) ? f_in[0] : (op == ALU_SRA) ? amsb :
                       (op == ALU_RRC) ? a[0] : 1'b0;
                r    = (a_m >> 1) | (32'(fill) << (n - 1));
                c    = a[0];
            end
            default: ;
        endcase
        if (op inside {ALU_RL, ALU_RLC, ALU_SLA, ALU_SLL, ALU_RR, ALU_RRC, ALU_SRA, ALU_SRL}) begin
            h  = 1'b0;
            v  = even_parity(r, wd);
            nf = 1'b0;
        end
        if (op != ALU_MOVE && op != ALU_CPL) begin
            s = r[n-1];
            z = (r == '0);
        end
        ref_result = {s, z, 1'b0, h, 1'b0, v, nf, c, r};
    endfunction

    task automatic apply_case(input case_t tc);
        op0     = tc.op0;
        op1     = tc.op1;
        imm     = tc.imm;
        sel_imm = tc.sel_imm;
        sel     = tc.sel;
        w       = tc.w;
        flag_we = tc.flag_we;
    endtask

    initial begin
        case_t           tc;
        alu_op_t         op_sel;
        flags_t          exp_flags;
        logic [39:0]     res;
        string           name;
        seed    = 32'h1590dbf5;
        rst     = 1'b1;
        cen     = 1'b1;
        op0     = '0;
        op1     = '0;
        imm     = '0;
        sel_imm = 1'b0;
        sel     = ALU_NOP;
        w       = '0;
        flag_we = 1'b0;
        exp_flags = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        check_value("reset dout", 32'h0, dout);
        check_value("reset flags", 32'h0, 32'(flags));
        check_value("reset alu_we", 32'h0, 32'(alu_we));
        check_value("reset flag_only", 32'h0, 32'(flag_only));
        for (int k = 0; k < NUM_CASES; k++) begin
            tc = case_tab[k];
            if (tc.rnd) begin
                tc.op0       = $random(seed);
                tc.op1       = $random(seed);
                tc.imm       = $random(seed);
                res          = ref_result(tc.sel, tc.op0, tc.sel_imm ? tc.imm : tc.op1,
                                          tc.w, exp_flags);
                tc.exp_flags = res[39:32];
                tc.exp_dout  = res[31:0];
            end
            apply_case(tc);
            @(posedge clk);
            #DRIVE_DLY;
            op_sel = tc.sel;
            name   = $sformatf("case %0d %s", k, op_sel.name());
            check_value({name, " dout"}, tc.exp_dout, dout);
            check_value({name, " flags"}, 32'(tc.exp_flags), 32'(flags));
            check_value({name, " alu_we"}, 32'(tc.w), 32'(alu_we));
            check_value({name, " flag_only"}, 32'(tc.flag_we), 32'(flag_only));
            exp_flags = tc.exp_flags;
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
